/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width.
`define XLEN 32

// data memory holds 2**DMEM_DEPTH_LOG2 words.
`define DMEM_DEPTH_LOG2 8

// cycles ready stays low after a command is taken.
// read data comes back on the last of them.
`define DMEM_BUSY_CYCLES 2

`endif

/* source/core_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_addr_t;
    typedef logic [3:0]       wb_sel_t;

    typedef enum logic [3:0] {
        MEM_X,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_RDATA
    } mem_state_e;

    // record from execute.
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_out;    // doubles as the memory address.
        word_t     rs2_data;
        logic      br_flg;
        word_t     br_target;
        mem_op_e   mem_op;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        logic      jmp_flg;
        logic      is_ecall;
    } ex_mem_t;

    // record to writeback.
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_out;
        logic      br_flg;
        word_t     br_target;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        logic      jmp_flg;
        logic      is_ecall;
        word_t     read_data;
    } mem_wb_t;

    typedef struct packed {
        logic  start;
        logic  write;
        word_t addr;
        word_t wdata;
        word_t wmask;    // one bit per data bit.
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
        logic  rdata_valid;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* source/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module memory_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  ex_mem_t  ex_mem,
    output logic     stall,
    output mem_wb_t  mem_wb,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    mem_state_e state;
    mem_state_e state_next;

    ex_mem_t    in_rec;    // live record, squashed by flush.
    ex_mem_t    saved;
    ex_mem_t    src;

    logic       in_mem;
    logic       in_store;
    logic       saved_store;
    logic       done;

    word_t      load_ext;
    logic       wb_valid_q;
    mem_wb_t    wb_q;

    function automatic logic is_store_op(mem_op_e op);
        return op == MEM_SB || op == MEM_SH || op == MEM_SW;
    endfunction

    function automatic word_t store_mask(mem_op_e op);
        case (op)
            MEM_SB:  return word_t'(8'hff);
            MEM_SH:  return word_t'(16'hffff);
            default: return '1;
        endcase
    endfunction

    always_comb begin
        in_rec       = ex_mem;
        in_rec.valid = ex_mem.valid && !flush;
    end

    assign in_mem      = in_rec.valid && in_rec.mem_op != MEM_X;
    assign in_store    = in_mem && is_store_op(in_rec.mem_op);
    assign saved_store = is_store_op(saved.mem_op);

    // live record while idle, saved copy while waiting.
    assign src = (state == ST_IDLE) ? in_rec : saved;

    always_comb begin
        mem_req.start = 1'b0;
        if (!flush) begin
            case (state)
                ST_IDLE:       mem_req.start = in_mem;
                ST_WAIT_READY: mem_req.start = 1'b1;    // held until taken.
                default:       mem_req.start = 1'b0;
            endcase
        end
        mem_req.write = is_store_op(src.mem_op);
        mem_req.addr  = src.alu_out;
        mem_req.wdata = src.rs2_data;
        mem_req.wmask = store_mask(src.mem_op);
    end

    // record finishes this cycle.
    always_comb begin
        case (state)
            ST_IDLE:       done = !in_mem || (in_store && mem_rsp.ready);
            ST_WAIT_READY: done = saved_store && mem_rsp.ready;
            ST_WAIT_RDATA: done = mem_rsp.rdata_valid;
            default:       done = 1'b1;
        endcase
    end

    assign stall = !flush && !done;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (in_mem) begin
                    if (!mem_rsp.ready)
                        state_next = ST_WAIT_READY;
                    else if (!in_store)
                        state_next = ST_WAIT_RDATA;
                end
            end
            ST_WAIT_READY: begin
                if (mem_rsp.ready)
                    state_next = saved_store ? ST_IDLE : ST_WAIT_RDATA;
            end
            ST_WAIT_RDATA: begin
                if (mem_rsp.rdata_valid)
                    state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
        if (flush)
            state_next = ST_IDLE;    // drops any pending response too.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE)
            saved <= in_rec;
    end

    always_comb begin
        case (saved.mem_op)
            MEM_LB:  load_ext = {{(`XLEN-8){mem_rsp.rdata[7]}}, mem_rsp.rdata[7:0]};
            MEM_LBU: load_ext = {{(`XLEN-8){1'b0}}, mem_rsp.rdata[7:0]};
            MEM_LH:  load_ext = {{(`XLEN-16){mem_rsp.rdata[15]}}, mem_rsp.rdata[15:0]};
            MEM_LHU: load_ext = {{(`XLEN-16){1'b0}}, mem_rsp.rdata[15:0]};
            default: load_ext = mem_rsp.rdata;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= done && src.valid && !flush;
    end

    always_ff @(posedge clk) begin
        if (done) begin
            wb_q.valid     <= src.valid;
            wb_q.pc        <= src.pc;
            wb_q.alu_out   <= src.alu_out;
            wb_q.br_flg    <= src.br_flg;
            wb_q.br_target <= src.br_target;
            wb_q.rf_wen    <= src.rf_wen;
            wb_q.wb_sel    <= src.wb_sel;
            wb_q.wb_addr   <= src.wb_addr;
            wb_q.jmp_flg   <= src.jmp_flg;
            wb_q.is_ecall  <= src.is_ecall;
            // only a load finishes in ST_WAIT_RDATA.
            wb_q.read_data <= (state == ST_WAIT_RDATA) ? load_ext : '0;
        end
    end

    always_comb begin
        mem_wb       = wb_q;
        mem_wb.valid = wb_valid_q;
    end

endmodule

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module data_memory
    import core_pkg::*;
#(
    parameter int DEPTH_LOG2 = `DMEM_DEPTH_LOG2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int BUSY  = `DMEM_BUSY_CYCLES;
    localparam int CNT_W = $clog2(BUSY + 1);

    word_t                 mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] idx;
    logic [CNT_W-1:0]      busy_cnt;
    logic                  read_pending;
    logic                  ready;
    logic                  fire;
    word_t                 rdata_q;

    assign idx   = mem_req.addr[DEPTH_LOG2+1:2];    // byte offset dropped.
    assign ready = busy_cnt == '0;
    assign fire  = mem_req.start && ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt     <= '0;
            read_pending <= 1'b0;
        end else if (fire) begin
            busy_cnt     <= CNT_W'(BUSY);
            read_pending <= !mem_req.write;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == CNT_W'(1))
                read_pending <= 1'b0;
        end
    end

    // masked write, read data latched at transfer.
    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_req.write)
                mem[idx] <= (mem[idx] & ~mem_req.wmask) | (mem_req.wdata & mem_req.wmask);
            else
                rdata_q <= mem[idx];
        end
    end

    always_comb begin
        mem_rsp.ready       = ready;
        mem_rsp.rdata       = rdata_q;
        // last busy cycle of a read.
        mem_rsp.rdata_valid = read_pending && busy_cnt == CNT_W'(1);
    end

endmodule

`default_nettype wire

/* source/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    flush,
    input  ex_mem_t ex_mem,
    output logic    stall,
    output mem_wb_t mem_wb
);

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    memory_stage stage_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .ex_mem  (ex_mem),
        .stall   (stall),
        .mem_wb  (mem_wb),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    // depth from the default.
    data_memory dmem_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

/* tb/mem_subsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_properties
    import core_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     flush,
    input ex_mem_t  ex_mem,
    input logic     stall,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp
);

    int   fail_count = 0;
    logic read_out;    // read taken, data not back yet.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            read_out <= 1'b0;
        else if (mem_req.start && mem_rsp.ready && !mem_req.write)
            read_out <= 1'b1;
        else if (mem_rsp.rdata_valid || flush)
            read_out <= 1'b0;
    end

    // a raised command stays put until the memory takes it.
    property req_held;
        @(posedge clk) disable iff (!arst_n)
        mem_req.start && !mem_rsp.ready && !flush
            |=> flush || (mem_req.start && $stable(mem_req));
    endproperty

    // no new command while read data is still owed.
    property no_start_while_read_out;
        @(posedge clk) disable iff (!arst_n)
        read_out |-> !mem_req.start;
    endproperty

    property no_stall_when_idle_input;
        @(posedge clk) disable iff (!arst_n)
        !ex_mem.valid |-> !stall;
    endproperty

    assert property (req_held) else begin
        fail_count++;
        $error("memory command changed before transfer");
    end
    assert property (no_start_while_read_out) else begin
        fail_count++;
        $error("start raised while a read is outstanding");
    end
    assert property (no_stall_when_idle_input) else begin
        fail_count++;
        $error("stall high for invalid input");
    end

endmodule

bind memory_stage mem_subsystem_properties props_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (flush),
    .ex_mem  (ex_mem),
    .stall   (stall),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

`default_nettype wire

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_mem_subsystem
    import core_pkg::*;
();

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 4;
    localparam int    DEPTH        = 2**`DMEM_DEPTH_LOG2;
    localparam word_t A0           = 32'h0000_0010;
    localparam word_t A1           = 32'h0000_0024;
    localparam word_t A2           = 32'h0000_03fc;    // last word.

    typedef struct {
        logic    valid;
        mem_op_e op;
        word_t   addr;
        word_t   wdata;
        logic    flush;
        logic    fixed;
        word_t   exp;
    } entry_t;

    logic    clk;
    logic    arst_n;
    logic    flush;
    ex_mem_t ex_mem;
    logic    stall;
    mem_wb_t mem_wb;

    entry_t  table_q[$];
    mem_wb_t exp_q[$];
    int      cyc_q[$];
    word_t   shadow [DEPTH];
    int      cycle = 0;
    int      value_errors = 0;
    int      other_errors = 0;

    mem_subsystem_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .ex_mem (ex_mem),
        .stall  (stall),
        .mem_wb (mem_wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic is_load(mem_op_e op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic word_t lane_mask(mem_op_e op);
        case (op)
            MEM_SB:  return 32'h0000_00ff;
            MEM_SH:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic word_t extend_load(mem_op_e op, word_t w);
        case (op)
            MEM_LB:  return word_t'($signed(w[7:0]));
            MEM_LBU: return word_t'(w[7:0]);
            MEM_LH:  return word_t'($signed(w[15:0]));
            MEM_LHU: return word_t'(w[15:0]);
            default: return w;
        endcase
    endfunction

    task automatic add_entry(input logic v, input mem_op_e op, input word_t addr,
                             input word_t wdata, input logic fl, input logic fixed,
                             input word_t exp);
        entry_t e;
        e = '{v, op, addr, wdata, fl, fixed, exp};
        table_q.push_back(e);
    endtask

    // valid, op, address, store data, flush, fixed, expected load.
    task automatic build_table();
        add_entry(1'b1, MEM_SW,  A0, 32'h1234_5678, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_SW,  A1, 32'hcafe_f08c, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A0, '0, 1'b0, 1'b1, 32'h1234_5678);
        add_entry(1'b1, MEM_LB,  A1, '0, 1'b0, 1'b1, 32'hffff_ff8c);
        add_entry(1'b1, MEM_LBU, A1, '0, 1'b0, 1'b1, 32'h0000_008c);
        add_entry(1'b1, MEM_LH,  A1, '0, 1'b0, 1'b1, 32'hffff_f08c);
        add_entry(1'b1, MEM_LHU, A1, '0, 1'b0, 1'b1, 32'h0000_f08c);
        add_entry(1'b1, MEM_LB,  A0, '0, 1'b0, 1'b1, 32'h0000_0078);
        add_entry(1'b1, MEM_LH,  A0, '0, 1'b0, 1'b1, 32'h0000_5678);
        add_entry(1'b1, MEM_SB,  A0, 32'haaaa_aa9d, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A0, '0, 1'b0, 1'b1, 32'h1234_569d);
        add_entry(1'b1, MEM_SH,  A1, 32'h5555_1234, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A1, '0, 1'b0, 1'b1, 32'hcafe_1234);
        add_entry(1'b1, MEM_SW,  A2, 32'h0bad_f00d, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_X,   32'h0bad_0000, 32'h1111_1111, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A2, '0, 1'b0, 1'b1, 32'h0bad_f00d);
        add_entry(1'b0, MEM_SW,  A0, 32'hffff_ffff, 1'b0, 1'b0, '0);    // invalid store.
        add_entry(1'b1, MEM_SW,  A0, 32'hdead_beef, 1'b1, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A0, '0, 1'b0, 1'b1, 32'h1234_569d);
        add_entry(1'b1, MEM_LW,  A1, '0, 1'b1, 1'b0, '0);
        add_entry(1'b1, MEM_SB,  A1, 32'hffff_ff7f, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_SH,  A2, 32'h7777_8001, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LB,  A1, '0, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LH,  A2, '0, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LHU, A2, '0, 1'b0, 1'b0, '0);
        add_entry(1'b0, MEM_X,   A1, '0, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LBU, A1, '0, 1'b0, 1'b0, '0);
        add_entry(1'b1, MEM_LW,  A1, '0, 1'b0, 1'b0, '0);
    endtask

    function automatic ex_mem_t make_record(entry_t e, int i);
        ex_mem_t r;
        r.valid     = e.valid;
        r.pc        = $urandom();
        r.alu_out   = e.addr;
        r.rs2_data  = e.wdata;
        r.br_flg    = 1'($urandom());
        r.br_target = $urandom();
        r.mem_op    = e.op;
        r.rf_wen    = is_load(e.op);
        r.wb_sel    = wb_sel_t'(i);
        r.wb_addr   = reg_addr_t'($urandom());
        r.jmp_flg   = (i % 3 == 0);
        r.is_ecall  = (i % 7 == 6);
        return r;
    endfunction

    function automatic mem_wb_t expected_record(ex_mem_t rec, word_t rd);
        mem_wb_t r;
        r.valid     = rec.valid;
        r.pc        = rec.pc;
        r.alu_out   = rec.alu_out;
        r.br_flg    = rec.br_flg;
        r.br_target = rec.br_target;
        r.rf_wen    = rec.rf_wen;
        r.wb_sel    = rec.wb_sel;
        r.wb_addr   = rec.wb_addr;
        r.jmp_flg   = rec.jmp_flg;
        r.is_ecall  = rec.is_ecall;
        r.read_data = rd;
        return r;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // shadow memory and expected output for a record taken by the stage.
    task automatic accept_record(input entry_t e, input ex_mem_t rec);
        int    idx;
        word_t rd;
        idx = e.addr[`DMEM_DEPTH_LOG2+1:2];
        rd  = '0;
        if (e.valid && !e.flush) begin
            if (is_store(e.op))
                shadow[idx] = (shadow[idx] & ~lane_mask(e.op)) | (e.wdata & lane_mask(e.op));
            else if (is_load(e.op))
                rd = e.fixed ? e.exp : extend_load(e.op, shadow[idx]);
            exp_q.push_back(expected_record(rec, rd));
            cyc_q.push_back(cycle + 1);
        end
    endtask

    task automatic present_entry(input int i);
        entry_t  e;
        ex_mem_t rec;
        mem_wb_t drop;
        int      stalls;
        logic    quick;
        e      = table_q[i];
        rec    = make_record(e, i);
        quick  = !e.valid || e.flush || e.op == MEM_X;
        stalls = 0;
        ex_mem = rec;
        flush  = e.flush;
        #(CLK_PERIOD / 4);
        while (stall) begin
            stalls++;
            @(negedge clk);    // upstream holds the record.
            #(CLK_PERIOD / 4);
        end
        accept_record(e, rec);
        if (quick)
            check_word(stalls, 0, "stall cycles of a pass-through record");
        if (is_load(e.op) && !quick) begin
            assert (stalls >= `DMEM_BUSY_CYCLES) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: load released after %0d stalls", $time, stalls);
            end
        end
        @(negedge clk);
        if (!e.valid || e.flush) begin
            drop       = expected_record(rec, '0);
            drop.valid = 1'b0;    // fields pass, valid does not.
            check_word(mem_wb.valid, '0, "mem_wb.valid of a dropped record");
            check_word(mem_wb.read_data, '0, "read_data of a dropped record");
            assert (mem_wb === drop) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: dropped mem_wb is %h, expected %h",
                         $time, mem_wb, drop);
            end
        end
    endtask

    // in-order compare of every valid record leaving the stage.
    always @(negedge clk) begin : wb_monitor
        mem_wb_t exp;
        int      exp_cyc;
        if (arst_n && mem_wb.valid) begin
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("mem_wb carried a record that was not expected at %0t", $time);
            end
            if (exp_q.size() != 0) begin
                exp     = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                check_word(mem_wb.read_data, exp.read_data, "mem_wb.read_data");
                check_word(mem_wb.pc, exp.pc, "mem_wb.pc");
                check_word(cycle, exp_cyc, "arrival cycle of record");
                assert (mem_wb === exp) else begin
                    value_errors++;
                    $display("CHECK FAILED at %0t: mem_wb is %h, expected %h",
                             $time, mem_wb, exp);
                end
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        #1;
        limit_ns = table_q.size() * (`DMEM_BUSY_CYCLES + 4) * CLK_PERIOD * 2;
        #(limit_ns);
        $display("timeout: the run did not end within %0d ns", limit_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'he8ff));
        arst_n = 1'b0;
        flush  = 1'b0;
        ex_mem = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_word(mem_wb.valid, '0, "mem_wb.valid after reset");
        check_word(stall, '0, "stall after reset");
        for (int i = 0; i < table_q.size(); i++)
            present_entry(i);
        ex_mem = '0;
        flush  = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);    // stray records.
        other_errors += dut_i.stage_i.props_i.fail_count;    // handshake assertions.
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
source/core_pkg.sv
source/memory_stage.sv
source/data_memory.sv
source/mem_subsystem_top.sv
tb/mem_subsystem_properties.sv
tb/tb_mem_subsystem.sv
